// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_opnd_fetch
out=$(./obj_dir/Vtb_opnd_fetch || true)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
	exit 0
else
	exit 1
fi

// File: src.f
src/opf_pkg.sv
src/inst_predecode.sv
src/gpr_file.sv
src/opnd_dep_table.sv
src/regs_rd.sv
src/opnd_fetch_top.sv
verif/clk_rst_gen.sv
verif/tb_opnd_fetch.sv

// File: src/gpr_file.sv
// general register file: 31 x 32 bit, x0 hard zero, two read ports, one write port
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic [4:0]  raddr0_i,
	input  logic [4:0]  raddr1_i,
	output logic [31:0] rdata0_o,
	output logic [31:0] rdata1_o,
	input  logic        we_i,
	input  logic [4:0]  waddr_i,
	input  logic [31:0] wdata_i
);

	logic [31:0] regs [1:31]; // x1..x31

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we_i && waddr_i != 5'd0)
		begin
			regs[waddr_i] <= wdata_i; // retire writeback
		end
	end

	// combinational reads, x0 returns zero
	assign rdata0_o = (raddr0_i == 5'd0) ? 32'd0 : regs[raddr0_i];
	assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];

	// the table never retires x0, since no writer to x0 is ever dispatched
	a_no_x0_write: assert property (
		@(posedge aclk) disable iff (!aresetn)
		we_i |-> (waddr_i != 5'd0)
	);

endmodule

`default_nettype wire

// File: src/inst_predecode.sv
// combinational pre-decoder: class flags, register-valid flags, csr address
`timescale 1ns/1ps
`default_nettype none

module inst_predecode
	import opf_pkg::*;
(
	input  inst_word_u             inst_i,
	output logic [pdc_w-1:0]       pdc_o
);

	logic [6:0] opc;
	logic [2:0] f3;
	logic       m_ext; // funct7 of the M extension

	assign opc   = inst_i.r_fmt.opcode;
	assign f3    = inst_i.r_fmt.funct3;
	assign m_ext = (inst_i.r_fmt.funct7 == 7'b0000001);

	always_comb
	begin
		pdc_o = '0;
		pdc_o[pdc_csr_addr +: 12] = inst_i.i_fmt.imm12; // only meaningful for csr ops
		case (opc)
			7'b0110111, 7'b0010111: // lui, auipc
				pdc_o[pdc_rd_vld] = 1'b1;
			7'b1101111: // jal
			begin
				pdc_o[pdc_jal]    = 1'b1;
				pdc_o[pdc_rd_vld] = 1'b1;
			end
			7'b1100111: // jalr
			begin
				pdc_o[pdc_jalr]    = 1'b1;
				pdc_o[pdc_rs1_vld] = 1'b1;
				pdc_o[pdc_rd_vld]  = 1'b1;
			end
			7'b1100011: // conditional branch
			begin
				pdc_o[pdc_branch]  = 1'b1;
				pdc_o[pdc_rs1_vld] = 1'b1;
				pdc_o[pdc_rs2_vld] = 1'b1;
			end
			7'b0000011: // load
			begin
				pdc_o[pdc_load]    = 1'b1;
				pdc_o[pdc_rs1_vld] = 1'b1;
				pdc_o[pdc_rd_vld]  = 1'b1;
			end
			7'b0100011: // store, no rd
			begin
				pdc_o[pdc_store]   = 1'b1;
				pdc_o[pdc_rs1_vld] = 1'b1;
				pdc_o[pdc_rs2_vld] = 1'b1;
			end
			7'b0010011: // op-imm
			begin
				pdc_o[pdc_rs1_vld] = 1'b1;
				pdc_o[pdc_rd_vld]  = 1'b1;
			end
			7'b0110011: // op, incl. mul/div/rem
			begin
				pdc_o[pdc_rs1_vld] = 1'b1;
				pdc_o[pdc_rs2_vld] = 1'b1;
				pdc_o[pdc_rd_vld]  = 1'b1;
				pdc_o[pdc_mul]     = m_ext & ~f3[2];
				pdc_o[pdc_div]     = m_ext & f3[2] & ~f3[1];
				pdc_o[pdc_rem]     = m_ext & f3[2] & f3[1];
			end
			7'b0001111: ; // fence, no operands
			7'b1110011: // system, csr when funct3 nonzero
			begin
				pdc_o[pdc_csr]     = (f3 != 3'b000);
				pdc_o[pdc_rs1_vld] = (f3 != 3'b000) & ~f3[2]; // csrr*i uses uimm
				pdc_o[pdc_rd_vld]  = (f3 != 3'b000);
			end
			default:
				pdc_o[pdc_illegal] = 1'b1; // unknown opcode
		endcase
	end

endmodule

`default_nettype wire

// File: src/opf_pkg.sv
// functional-unit ids, pre-decode vector layout and instruction-word union
`default_nettype none

package opf_pkg;

	localparam int fu_id_w = 3; // fu id width

	localparam logic [fu_id_w-1:0] fu_alu = 3'd0;
	localparam logic [fu_id_w-1:0] fu_csr = 3'd1;
	localparam logic [fu_id_w-1:0] fu_lsu = 3'd2;
	localparam logic [fu_id_w-1:0] fu_mul = 3'd3;
	localparam logic [fu_id_w-1:0] fu_div = 3'd4; // div and rem share the divider

	// bit positions in the pre-decode vector
	localparam int pdc_rem      = 0;
	localparam int pdc_div      = 1;
	localparam int pdc_mul      = 2;
	localparam int pdc_store    = 3;
	localparam int pdc_load     = 4;
	localparam int pdc_csr      = 5;
	localparam int pdc_jalr     = 6;
	localparam int pdc_jal      = 7;
	localparam int pdc_branch   = 8;
	localparam int pdc_illegal  = 9;
	localparam int pdc_rs1_vld  = 10;
	localparam int pdc_rs2_vld  = 11;
	localparam int pdc_rd_vld   = 12;
	localparam int pdc_csr_addr = 13; // 12-bit field
	localparam int pdc_w        = 25;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm12; // also the csr address
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
	} inst_word_u;

endpackage

`default_nettype wire

// File: src/opnd_dep_table.sv
// pending-writer table: result capture, operand source lookup, retire writeback, flush
`timescale 1ns/1ps
`default_nettype none

module opnd_dep_table
	import opf_pkg::*;
#(
	parameter int TID_WIDTH = 8,
	parameter int LSN_FU_N  = 5
)(
	input  logic                          aclk,
	input  logic                          aresetn,
	input  logic                          flush_i,
	input  logic                          dsp_vld_i,
	input  logic [4:0]                    dsp_rd_i,
	input  logic [TID_WIDTH-1:0]          dsp_tid_i,
	input  logic [fu_id_w-1:0]            dsp_fuid_i,
	input  logic [LSN_FU_N-1:0]           fu_res_vld_i,
	input  logic [LSN_FU_N*TID_WIDTH-1:0] fu_res_tid_i,
	input  logic [LSN_FU_N*32-1:0]        fu_res_data_i,
	input  logic                          retire_vld_i,
	input  logic [4:0]                    retire_rd_i,
	input  logic [4:0]                    lk1_rs_i,
	input  logic [4:0]                    lk2_rs_i,
	output logic                          op1_from_reg_o,
	output logic                          op1_from_rob_o,
	output logic                          op1_from_byp_o,
	output logic [fu_id_w-1:0]            op1_fuid_o,
	output logic [TID_WIDTH-1:0]          op1_tid_o,
	output logic [31:0]                   op1_saved_o,
	output logic                          op2_from_reg_o,
	output logic                          op2_from_rob_o,
	output logic                          op2_from_byp_o,
	output logic [fu_id_w-1:0]            op2_fuid_o,
	output logic [TID_WIDTH-1:0]          op2_tid_o,
	output logic [31:0]                   op2_saved_o,
	output logic                          gpr_we_o,
	output logic [4:0]                    gpr_waddr_o,
	output logic [31:0]                   gpr_wdata_o
);

	localparam logic [1:0] st_free = 2'd0;
	localparam logic [1:0] st_wait = 2'd1; // writer in flight
	localparam logic [1:0] st_done = 2'd2; // result held, not retired

	logic [1:0]           ent_st   [32];
	logic [TID_WIDTH-1:0] ent_tid  [32];
	logic [fu_id_w-1:0]   ent_fuid [32];
	logic [31:0]          ent_data [32];
	logic [31:0]          res_hit; // entry's producer is on the bus now

	always_comb
	begin
		for (int i = 0; i < 32; i++)
			res_hit[i] = fu_res_vld_i[ent_fuid[i]] &&
				(fu_res_tid_i[ent_fuid[i]*TID_WIDTH +: TID_WIDTH] == ent_tid[i]);
	end

	// entry state, x0 stays free
	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
		begin
			for (int i = 0; i < 32; i++)
				ent_st[i] <= st_free;
		end
		else
		begin
			for (int i = 1; i < 32; i++)
			begin
				if (flush_i)
					ent_st[i] <= st_free; // drop every pending writer
				else if (dsp_vld_i && dsp_rd_i == 5'(i))
					ent_st[i] <= st_wait; // latest writer wins
				else if (retire_vld_i && retire_rd_i == 5'(i))
					ent_st[i] <= st_free;
				else if (ent_st[i] == st_wait && res_hit[i])
					ent_st[i] <= st_done;
			end
		end
	end

	// producer tags and captured results
	always_ff @(posedge aclk)
	begin
		for (int i = 1; i < 32; i++)
		begin
			if (dsp_vld_i && dsp_rd_i == 5'(i))
			begin
				ent_tid[i]  <= dsp_tid_i;
				ent_fuid[i] <= dsp_fuid_i;
			end
			if (ent_st[i] == st_wait && res_hit[i])
				ent_data[i] <= fu_res_data_i[ent_fuid[i]*32 +: 32];
		end
	end

	// operand lookups
	assign op1_from_reg_o = (ent_st[lk1_rs_i] == st_free);
	assign op1_from_rob_o = (ent_st[lk1_rs_i] == st_done);
	assign op1_from_byp_o = (ent_st[lk1_rs_i] == st_wait);
	assign op1_fuid_o     = ent_fuid[lk1_rs_i];
	assign op1_tid_o      = ent_tid[lk1_rs_i];
	assign op1_saved_o    = ent_data[lk1_rs_i];

	assign op2_from_reg_o = (ent_st[lk2_rs_i] == st_free);
	assign op2_from_rob_o = (ent_st[lk2_rs_i] == st_done);
	assign op2_from_byp_o = (ent_st[lk2_rs_i] == st_wait);
	assign op2_fuid_o     = ent_fuid[lk2_rs_i];
	assign op2_tid_o      = ent_tid[lk2_rs_i];
	assign op2_saved_o    = ent_data[lk2_rs_i];

	// retire writes the held result back
	assign gpr_we_o    = retire_vld_i;
	assign gpr_waddr_o = retire_rd_i;
	assign gpr_wdata_o = ent_data[retire_rd_i];

	// environment retires only results that came back on the bus
	a_retire_done: assert property (
		@(posedge aclk) disable iff (!aresetn)
		retire_vld_i |-> (ent_st[retire_rd_i] == st_done)
	);

endmodule

`default_nettype wire

// File: src/opnd_fetch_top.sv
// operand-fetch top: pre-decoder, register file, dependency table and read stage
`timescale 1ns/1ps
`default_nettype none

module opnd_fetch_top
	import opf_pkg::*;
#(
	parameter int TID_WIDTH = 8,
	parameter int LSN_FU_N  = 5
)(
	input  logic                          aclk,
	input  logic                          aresetn,
	input  logic                          flush_i,
	input  logic [31:0]                   s_pc_i,
	input  inst_word_u                    s_inst_i,
	input  logic [TID_WIDTH-1:0]          s_tid_i,
	input  logic                          s_valid_i,
	output logic                          s_ready_o,
	output logic [31:0]                   m_pc_o,
	output inst_word_u                    m_inst_o,
	output logic [pdc_w-1:0]              m_pdc_o,
	output logic [TID_WIDTH-1:0]          m_tid_o,
	output logic [fu_id_w-1:0]            m_fuid_o,
	output logic [4:0]                    m_rd_o,
	output logic                          m_op1_rdy_o,
	output logic                          m_op2_rdy_o,
	output logic [31:0]                   m_op1_o,
	output logic [31:0]                   m_op2_o,
	output logic [fu_id_w-1:0]            m_op1_fuid_o,
	output logic [fu_id_w-1:0]            m_op2_fuid_o,
	output logic [TID_WIDTH-1:0]          m_op1_tid_o,
	output logic [TID_WIDTH-1:0]          m_op2_tid_o,
	output logic                          m_valid_o,
	input  logic                          m_ready_i,
	input  logic [LSN_FU_N-1:0]           fu_res_vld_i,
	input  logic [LSN_FU_N*TID_WIDTH-1:0] fu_res_tid_i,
	input  logic [LSN_FU_N*32-1:0]        fu_res_data_i,
	input  logic                          retire_vld_i,
	input  logic [4:0]                    retire_rd_i
);

	logic [pdc_w-1:0]     pdc;
	logic [4:0]           rs1_id, rs2_id;
	logic [31:0]          gpr_rdata0, gpr_rdata1;
	logic                 gpr_we;
	logic [4:0]           gpr_waddr;
	logic [31:0]          gpr_wdata;
	logic                 op1_from_reg, op1_from_rob, op1_from_byp;
	logic                 op2_from_reg, op2_from_rob, op2_from_byp;
	logic [fu_id_w-1:0]   op1_fuid, op2_fuid;
	logic [TID_WIDTH-1:0] op1_tid, op2_tid;
	logic [31:0]          op1_saved, op2_saved;
	logic                 dsp_vld; // output transfer records the writer

	assign dsp_vld = m_valid_o & m_ready_i;

	inst_predecode u_pdc (
		.inst_i (s_inst_i),
		.pdc_o  (pdc)
	);

	gpr_file u_gpr (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.raddr0_i (rs1_id),
		.raddr1_i (rs2_id),
		.rdata0_o (gpr_rdata0),
		.rdata1_o (gpr_rdata1),
		.we_i     (gpr_we),
		.waddr_i  (gpr_waddr),
		.wdata_i  (gpr_wdata)
	);

	opnd_dep_table #(.TID_WIDTH(TID_WIDTH), .LSN_FU_N(LSN_FU_N)) u_dep (
		.aclk (aclk), .aresetn (aresetn), .flush_i (flush_i),
		.dsp_vld_i (dsp_vld), .dsp_rd_i (m_rd_o),
		.dsp_tid_i (m_tid_o), .dsp_fuid_i (m_fuid_o),
		.fu_res_vld_i (fu_res_vld_i), .fu_res_tid_i (fu_res_tid_i),
		.fu_res_data_i (fu_res_data_i),
		.retire_vld_i (retire_vld_i), .retire_rd_i (retire_rd_i),
		.lk1_rs_i (rs1_id), .lk2_rs_i (rs2_id),
		.op1_from_reg_o (op1_from_reg), .op1_from_rob_o (op1_from_rob),
		.op1_from_byp_o (op1_from_byp), .op1_fuid_o (op1_fuid),
		.op1_tid_o (op1_tid), .op1_saved_o (op1_saved),
		.op2_from_reg_o (op2_from_reg), .op2_from_rob_o (op2_from_rob),
		.op2_from_byp_o (op2_from_byp), .op2_fuid_o (op2_fuid),
		.op2_tid_o (op2_tid), .op2_saved_o (op2_saved),
		.gpr_we_o (gpr_we), .gpr_waddr_o (gpr_waddr), .gpr_wdata_o (gpr_wdata)
	);

	regs_rd #(.TID_WIDTH(TID_WIDTH), .LSN_FU_N(LSN_FU_N)) u_rd (
		.aclk (aclk), .aresetn (aresetn), .flush_i (flush_i),
		.s_pc_i (s_pc_i), .s_inst_i (s_inst_i), .s_pdc_i (pdc),
		.s_tid_i (s_tid_i), .s_valid_i (s_valid_i), .s_ready_o (s_ready_o),
		.op1_from_reg_i (op1_from_reg), .op1_from_rob_i (op1_from_rob),
		.op1_from_byp_i (op1_from_byp), .op1_fuid_i (op1_fuid),
		.op1_tid_i (op1_tid), .op1_saved_i (op1_saved),
		.op2_from_reg_i (op2_from_reg), .op2_from_rob_i (op2_from_rob),
		.op2_from_byp_i (op2_from_byp), .op2_fuid_i (op2_fuid),
		.op2_tid_i (op2_tid), .op2_saved_i (op2_saved),
		.rs1_id_o (rs1_id), .rs2_id_o (rs2_id),
		.gpr_rdata0_i (gpr_rdata0), .gpr_rdata1_i (gpr_rdata1),
		.fu_res_vld_i (fu_res_vld_i), .fu_res_tid_i (fu_res_tid_i),
		.fu_res_data_i (fu_res_data_i),
		.m_pc_o (m_pc_o), .m_inst_o (m_inst_o), .m_pdc_o (m_pdc_o),
		.m_tid_o (m_tid_o), .m_fuid_o (m_fuid_o), .m_rd_o (m_rd_o),
		.m_op1_rdy_o (m_op1_rdy_o), .m_op2_rdy_o (m_op2_rdy_o),
		.m_op1_o (m_op1_o), .m_op2_o (m_op2_o),
		.m_op1_fuid_o (m_op1_fuid_o), .m_op2_fuid_o (m_op2_fuid_o),
		.m_op1_tid_o (m_op1_tid_o), .m_op2_tid_o (m_op2_tid_o),
		.m_valid_o (m_valid_o), .m_ready_i (m_ready_i)
	);

endmodule

`default_nettype wire

// File: src/regs_rd.sv
// register-read stage with operand prefetch, bypass match, stage raw check and fu steering
`timescale 1ns/1ps
`default_nettype none

module regs_rd
	import opf_pkg::*;
#(
	parameter int TID_WIDTH = 8,
	parameter int LSN_FU_N  = 5
)(
	input  logic                          aclk,
	input  logic                          aresetn,
	input  logic                          flush_i,
	input  logic [31:0]                   s_pc_i,
	input  inst_word_u                    s_inst_i,
	input  logic [pdc_w-1:0]              s_pdc_i,
	input  logic [TID_WIDTH-1:0]          s_tid_i,
	input  logic                          s_valid_i,
	output logic                          s_ready_o,
	input  logic                          op1_from_reg_i,
	input  logic                          op1_from_rob_i,
	input  logic                          op1_from_byp_i,
	input  logic [fu_id_w-1:0]            op1_fuid_i,
	input  logic [TID_WIDTH-1:0]          op1_tid_i,
	input  logic [31:0]                   op1_saved_i,
	input  logic                          op2_from_reg_i,
	input  logic                          op2_from_rob_i,
	input  logic                          op2_from_byp_i,
	input  logic [fu_id_w-1:0]            op2_fuid_i,
	input  logic [TID_WIDTH-1:0]          op2_tid_i,
	input  logic [31:0]                   op2_saved_i,
	output logic [4:0]                    rs1_id_o,
	output logic [4:0]                    rs2_id_o,
	input  logic [31:0]                   gpr_rdata0_i,
	input  logic [31:0]                   gpr_rdata1_i,
	input  logic [LSN_FU_N-1:0]           fu_res_vld_i,
	input  logic [LSN_FU_N*TID_WIDTH-1:0] fu_res_tid_i,
	input  logic [LSN_FU_N*32-1:0]        fu_res_data_i,
	output logic [31:0]                   m_pc_o,
	output inst_word_u                    m_inst_o,
	output logic [pdc_w-1:0]              m_pdc_o,
	output logic [TID_WIDTH-1:0]          m_tid_o,
	output logic [fu_id_w-1:0]            m_fuid_o,
	output logic [4:0]                    m_rd_o,
	output logic                          m_op1_rdy_o,
	output logic                          m_op2_rdy_o,
	output logic [31:0]                   m_op1_o,
	output logic [31:0]                   m_op2_o,
	output logic [fu_id_w-1:0]            m_op1_fuid_o,
	output logic [fu_id_w-1:0]            m_op2_fuid_o,
	output logic [TID_WIDTH-1:0]          m_op1_tid_o,
	output logic [TID_WIDTH-1:0]          m_op2_tid_o,
	output logic                          m_valid_o,
	input  logic                          m_ready_i
);

	logic [TID_WIDTH-1:0] lane_tid  [LSN_FU_N];
	logic [31:0]          lane_data [LSN_FU_N];
	logic                 accept; // input transfer
	logic                 op1_raw, op2_raw; // hit on rd of the stage
	logic                 op1_rdy, op2_rdy;
	logic [31:0]          op1_val, op2_val;
	logic [fu_id_w-1:0]   fuid_nxt;

	for (genvar g = 0; g < LSN_FU_N; g++)
	begin : g_lane
		assign lane_tid[g]  = fu_res_tid_i[g*TID_WIDTH +: TID_WIDTH];
		assign lane_data[g] = fu_res_data_i[g*32 +: 32];
	end

	assign rs1_id_o = s_inst_i.r_fmt.rs1; // to gpr and table
	assign rs2_id_o = s_inst_i.r_fmt.rs2;

	assign s_ready_o = ~flush_i & (~m_valid_o | m_ready_i);
	assign accept    = s_valid_i & s_ready_o;

	// RAW on the instruction still sitting in the stage
	assign op1_raw = m_valid_o && (m_rd_o != 5'd0) && (rs1_id_o == m_rd_o);
	assign op2_raw = m_valid_o && (m_rd_o != 5'd0) && (rs2_id_o == m_rd_o);

	// masked-or of the three sources
	assign op1_val = ({32{op1_from_reg_i}} & gpr_rdata0_i) |
		({32{op1_from_rob_i}} & op1_saved_i) |
		({32{op1_from_byp_i}} & lane_data[op1_fuid_i]);
	assign op2_val = ({32{op2_from_reg_i}} & gpr_rdata1_i) |
		({32{op2_from_rob_i}} & op2_saved_i) |
		({32{op2_from_byp_i}} & lane_data[op2_fuid_i]);

	assign op1_rdy = ~op1_raw & (op1_from_reg_i | op1_from_rob_i |
		(op1_from_byp_i & fu_res_vld_i[op1_fuid_i] & (lane_tid[op1_fuid_i] == op1_tid_i)));
	assign op2_rdy = ~op2_raw & (op2_from_reg_i | op2_from_rob_i |
		(op2_from_byp_i & fu_res_vld_i[op2_fuid_i] & (lane_tid[op2_fuid_i] == op2_tid_i)));

	// illegal goes to the alu for the trap path
	always_comb
	begin
		if (s_pdc_i[pdc_illegal])
			fuid_nxt = fu_alu;
		else if (s_pdc_i[pdc_csr])
			fuid_nxt = fu_csr;
		else if (s_pdc_i[pdc_load] | s_pdc_i[pdc_store])
			fuid_nxt = fu_lsu;
		else if (s_pdc_i[pdc_mul])
			fuid_nxt = fu_mul;
		else if (s_pdc_i[pdc_div] | s_pdc_i[pdc_rem])
			fuid_nxt = fu_div;
		else
			fuid_nxt = fu_alu;
	end

	always_ff @(posedge aclk or negedge aresetn)
	begin
		if (!aresetn)
			m_valid_o <= 1'b0;
		else if (flush_i)
			m_valid_o <= 1'b0; // empty the stage
		else if (~m_valid_o | m_ready_i)
			m_valid_o <= s_valid_i;
	end

	// stage payload loaded on accept
	always_ff @(posedge aclk)
	begin
		if (accept)
		begin
			m_pc_o       <= s_pc_i;
			m_inst_o     <= s_inst_i;
			m_pdc_o      <= s_pdc_i;
			m_tid_o      <= s_tid_i;
			m_fuid_o     <= fuid_nxt;
			m_rd_o       <= (s_pdc_i[pdc_store] | s_pdc_i[pdc_branch]) ?
				5'd0 : s_inst_i.r_fmt.rd; // no register written
			m_op1_rdy_o  <= op1_rdy;
			m_op2_rdy_o  <= op2_rdy;
			m_op1_o      <= op1_val;
			m_op2_o      <= op2_val;
			m_op1_fuid_o <= op1_raw ? m_fuid_o : op1_fuid_i;
			m_op2_fuid_o <= op2_raw ? m_fuid_o : op2_fuid_i;
			m_op1_tid_o  <= op1_raw ? m_tid_o : op1_tid_i;
			m_op2_tid_o  <= op2_raw ? m_tid_o : op2_tid_i;
		end
	end

	// table reports one source per operand
	a_one_src: assert property (
		@(posedge aclk) disable iff (!aresetn)
		s_valid_i |-> ($onehot0({op1_from_reg_i, op1_from_rob_i, op1_from_byp_i}) &&
			$onehot0({op2_from_reg_i, op2_from_rob_i, op2_from_byp_i}))
	);

endmodule

`default_nettype wire

// File: verif/clk_rst_gen.sv
// testbench clock of 20 ns period and active-low reset held for 5 cycles
`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RST_CYCLES = 5
)(
	output logic aclk_o,
	output logic aresetn_o
);

	initial
	begin
		aclk_o    = 1'b0;
		aresetn_o = 1'b0; // reset from time zero
		repeat (RST_CYCLES) @(posedge aclk_o);
		aresetn_o <= 1'b1; // released on an edge, like the stimulus
	end

	always #(PERIOD_NS / 2) aclk_o = ~aclk_o; // free running

endmodule

`default_nettype wire

// File: verif/opnd_patterns.txt
// sval mrdy flush ret rret lane rvld rtid rdata inst tid | mask
// srdy mval fuid rd r1 op1 f1 t1 r2 op2 mtid ; first column f ends the list
0 1 0 0 00 0 0 00 00000000 00000000 00 003 1 0 0 00 0 00000000 0 00 0 00000000 00
1 1 0 0 00 0 0 00 00000000 000002b3 01 003 1 0 0 00 0 00000000 0 00 0 00000000 00
0 1 0 0 00 0 0 00 00000000 00000000 00 73f 1 1 0 05 1 00000000 0 00 1 00000000 01
0 1 0 0 00 0 1 01 cafe0005 00000000 00 003 1 0 0 00 0 00000000 0 00 0 00000000 00
1 1 0 1 05 0 0 00 00000000 00028333 02 003 1 0 0 00 0 00000000 0 00 0 00000000 00
1 1 0 0 00 0 0 00 00000000 020283b3 03 4ff 1 1 0 06 1 cafe0005 0 01 0 00000000 02
1 1 0 0 00 0 0 00 00000000 00038433 04 7ff 1 1 3 07 1 cafe0005 0 01 1 00000000 03
1 1 0 0 00 0 0 00 00000000 000004a3 05 4df 1 1 0 08 0 00000000 3 03 0 00000000 04
1 1 0 0 00 0 0 00 00000000 00048533 06 41f 1 1 2 00 1 00000000 0 00 0 00000000 05
1 1 0 0 00 3 1 03 12345677 000385b3 07 43f 1 1 0 0a 1 00000000 0 00 0 00000000 06
1 1 0 0 00 0 1 55 deadbeef 00040633 08 4ff 1 1 0 0b 1 12345677 3 03 0 00000000 07
1 1 0 0 00 0 0 00 00000000 00002683 09 4df 1 1 0 0c 0 00000000 0 04 0 00000000 08
1 1 0 0 00 0 0 00 00000000 30001773 0a 40f 1 1 2 0d 0 00000000 0 00 0 00000000 09
1 1 0 0 00 0 0 00 00000000 020047b3 0b 40f 1 1 1 0e 0 00000000 0 00 0 00000000 0a
1 1 0 0 00 0 0 00 00000000 02006833 0c 40f 1 1 4 0f 0 00000000 0 00 0 00000000 0b
1 1 0 0 00 0 0 00 00000000 000008ff 0d 40f 1 1 4 10 0 00000000 0 00 0 00000000 0c
1 1 0 0 00 0 0 00 00000000 000001e3 0e 40f 1 1 0 11 0 00000000 0 00 0 00000000 0d
1 1 0 0 00 0 0 00 00000000 00018933 0f 40f 1 1 0 00 0 00000000 0 00 0 00000000 0e
1 1 0 0 00 0 0 00 00000000 000009b3 10 43f 1 1 0 12 1 00000000 0 00 0 00000000 0f
1 0 0 0 00 0 0 00 00000000 00000a33 11 40f 0 1 0 13 0 00000000 0 00 0 00000000 10
1 0 0 0 00 0 0 00 00000000 00000a33 11 40f 0 1 0 13 0 00000000 0 00 0 00000000 10
1 1 0 0 00 0 0 00 00000000 00000a33 11 40f 1 1 0 13 0 00000000 0 00 0 00000000 10
1 1 0 0 00 0 0 00 00000000 00000ab3 12 40f 1 1 0 14 0 00000000 0 00 0 00000000 11
1 0 1 0 00 0 0 00 00000000 00000b33 13 40f 0 1 0 15 0 00000000 0 00 0 00000000 12
1 1 0 0 00 0 0 00 00000000 00540bb3 14 003 1 0 0 00 0 00000000 0 00 0 00000000 00
0 1 0 0 00 0 0 00 00000000 00000000 00 73f 1 1 0 17 1 00000000 0 00 1 cafe0005 14
0 1 0 0 00 0 0 00 00000000 00000000 00 003 1 0 0 00 0 00000000 0 00 0 00000000 00
f 0 0 0 00 0 0 00 00000000 00000000 00 000 0 0 0 00 0 00000000 0 00 0 00000000 00

// File: verif/tb_opnd_fetch.sv
// operand-fetch testbench with pattern stimulus, field checks, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

module tb_opnd_fetch
	import opf_pkg::*;
;

	localparam int tid_w = 8;
	localparam int lsn_n = 5;
	localparam int ncol  = 23; // columns per pattern line
	localparam int max_l = 64;

	logic                    aclk, aresetn;
	logic                    flush, s_valid, m_ready, retire_vld;
	logic [31:0]             s_pc, s_inst;
	logic [tid_w-1:0]        s_tid;
	logic [4:0]              retire_rd;
	logic [lsn_n-1:0]        res_vld;
	logic [lsn_n*tid_w-1:0]  res_tid;
	logic [lsn_n*32-1:0]     res_data;
	logic                    s_ready, m_valid, op1_rdy, op2_rdy;
	logic [31:0]             m_pc, m_inst, op1, op2;
	logic [pdc_w-1:0]        m_pdc;
	logic [tid_w-1:0]        m_tid, op1_tid, op2_tid;
	logic [fu_id_w-1:0]      m_fuid, op1_fuid, op2_fuid;
	logic [4:0]              m_rd;
	logic [31:0]             pat [max_l*ncol]; // flat pattern memory
	logic [31:0]             inst_of_tid [256]; // instruction sent with each id
	int                      n_lines;
	int                      err_cnt;

	clk_rst_gen #(.PERIOD_NS(20), .RST_CYCLES(5)) u_clk (.aclk_o(aclk), .aresetn_o(aresetn));

	opnd_fetch_top #(.TID_WIDTH(tid_w), .LSN_FU_N(lsn_n)) DUT (
		.aclk (aclk), .aresetn (aresetn), .flush_i (flush),
		.s_pc_i (s_pc), .s_inst_i (s_inst), .s_tid_i (s_tid),
		.s_valid_i (s_valid), .s_ready_o (s_ready),
		.m_pc_o (m_pc), .m_inst_o (m_inst), .m_pdc_o (m_pdc),
		.m_tid_o (m_tid), .m_fuid_o (m_fuid), .m_rd_o (m_rd),
		.m_op1_rdy_o (op1_rdy), .m_op2_rdy_o (op2_rdy),
		.m_op1_o (op1), .m_op2_o (op2),
		.m_op1_fuid_o (op1_fuid), .m_op2_fuid_o (op2_fuid),
		.m_op1_tid_o (op1_tid), .m_op2_tid_o (op2_tid),
		.m_valid_o (m_valid), .m_ready_i (m_ready),
		.fu_res_vld_i (res_vld), .fu_res_tid_i (res_tid), .fu_res_data_i (res_data),
		.retire_vld_i (retire_vld), .retire_rd_i (retire_rd)
	);

	// one pattern line onto the DUT inputs
	task automatic drive_line(input int b);
		logic [lsn_n-1:0]       vld_v;
		logic [lsn_n*tid_w-1:0] tid_v;
		logic [lsn_n*32-1:0]    data_v;
		int                     lane;
		lane   = int'(pat[b+5]);
		vld_v  = '0;
		tid_v  = '0;
		data_v = '0;
		if (pat[b+6][0])
		begin
			vld_v[lane]               = 1'b1; // one result lane per line
			tid_v[lane*tid_w +: tid_w] = pat[b+7][tid_w-1:0];
			data_v[lane*32 +: 32]     = pat[b+8];
		end
		if (pat[b][0])
			inst_of_tid[pat[b+10][tid_w-1:0]] = pat[b+9];
		s_valid    <= pat[b][0];
		m_ready    <= pat[b+1][0];
		flush      <= pat[b+2][0];
		retire_vld <= pat[b+3][0];
		retire_rd  <= pat[b+4][4:0];
		res_vld    <= vld_v;
		res_tid    <= tid_v;
		res_data   <= data_v;
		s_inst     <= pat[b+9];
		s_tid      <= pat[b+10][tid_w-1:0];
		s_pc       <= {pat[b+10][29:0], 2'b00}; // pc tracks the id
	endtask

	task automatic check_field(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		assert (act_v === exp_v)
		else
		begin
			$display("ERR t=%0t %s exp=%h act=%h", $time, name, exp_v, act_v);
			err_cnt++;
		end
	endtask

	// compare the masked output fields of one line
	task automatic compare_line(input int b);
		logic [31:0] m;
		logic [31:0] exp_inst;
		m        = pat[b+11];
		exp_inst = inst_of_tid[pat[b+22][tid_w-1:0]]; // held item named by its id
		if (m[0])  check_field("s_ready_o", pat[b+12], 32'(s_ready));
		if (m[1])  check_field("m_valid_o", pat[b+13], 32'(m_valid));
		if (m[2])  check_field("m_fuid_o", pat[b+14], 32'(m_fuid));
		if (m[3])  check_field("m_rd_o", pat[b+15], 32'(m_rd));
		if (m[4])  check_field("m_op1_rdy_o", pat[b+16], 32'(op1_rdy));
		if (m[5])  check_field("m_op1_o", pat[b+17], op1);
		if (m[6])  check_field("m_op1_fuid_o", pat[b+18], 32'(op1_fuid));
		if (m[7])  check_field("m_op1_tid_o", pat[b+19], 32'(op1_tid));
		if (m[8])  check_field("m_op2_rdy_o", pat[b+20], 32'(op2_rdy));
		if (m[9])  check_field("m_op2_o", pat[b+21], op2);
		if (m[10]) check_field("m_tid_o", pat[b+22], 32'(m_tid));
		if (m[10])
		begin
			check_field("m_pc_o", {pat[b+22][29:0], 2'b00}, m_pc);
			check_field("m_inst_o", exp_inst, m_inst);
		end
		if (m[2] && m[10] && pat[b+14] == 32'(fu_csr))
			check_field("m_pdc_o csr address", 32'(exp_inst[31:20]),
				32'(m_pdc[pdc_csr_addr +: 12])); // imm12 of the held csr op
	endtask

	initial
	begin
		s_valid    = 1'b0;
		m_ready    = 1'b0;
		flush      = 1'b0;
		retire_vld = 1'b0;
		retire_rd  = '0;
		res_vld    = '0;
		res_tid    = '0;
		res_data   = '0;
		s_inst     = '0;
		s_tid      = '0;
		s_pc       = '0;
		err_cnt    = 0;
		n_lines    = 0;
		$readmemh("verif/opnd_patterns.txt", pat);
		while (n_lines < max_l && pat[n_lines*ncol] != 32'hf)
			n_lines++; // first column f ends the list
		assert (n_lines > 0)
		else
		begin
			$display("no pattern lines were read");
			err_cnt++;
		end
		fork
			begin
				#(20 * (n_lines + 20)); // watchdog
				$display("timeout, patterns did not finish in time");
				$display("Test failed");
				$finish;
			end
		join_none
		wait (aresetn === 1'b1);
		for (int i = 0; i < n_lines; i++)
		begin
			@(posedge aclk);
			drive_line(i * ncol);
			@(negedge aclk); // outputs settled
			compare_line(i * ncol);
		end
		$display("lines=%0d errors=%0d", n_lines, err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
